// ==== logic/clkPkg.sv ====
package clkPkg;

  // Diagnostic address, bit 3 picks control 00x or load 04x
  typedef logic [3:0] diagAddrT;

  // Data word, EBUS data bits 30 to 35
  typedef logic [5:0] diagDataT;

  // Burst count, two nibbles
  typedef logic [7:0] burstCountT;

  // Rate select, one opportunity every 1, 2, 4 or 8 cycles
  typedef logic [1:0] rateSelT;

  // Control functions 00x
  // Codes 0, 3 and 4 are not supported here
  typedef enum logic [2:0] {
    START       = 3'd1,
    SINGLE_STEP = 3'd2,
    BURST       = 3'd5,
    CLR_RESET   = 3'd6,
    SET_RESET   = 3'd7
  } ctlFuncE;

  // Load functions 04x
  localparam logic [2:0] LD_BURST_LSB = 3'd2;
  localparam logic [2:0] LD_BURST_MSB = 3'd3;
  localparam logic [2:0] LD_RATE = 3'd4;
  localparam logic [2:0] LD_DISABLE = 3'd5;

  // Diagnostic reads 10x
  localparam logic [2:0] RD_BURST = 3'd0;
  localparam logic [2:0] RD_STATUS = 3'd1;
  localparam logic [2:0] RD_CONFIG = 3'd2;

  // Rate phase counter width, covers the divide by 8
  localparam int RATE_DIV_W = 3;

  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    diagAddrT paddr;
    diagDataT pwdata;
  } apbReqT;

  typedef struct packed {
    logic     pready;
    logic     pslverr;
    diagDataT prdata;
  } apbRspT;

  // One-cycle control strobes to the gate
  typedef struct packed {
    logic start;
    logic step;
    logic burst;
    logic anyCtl;
  } clkFuncT;

  // Loaded clock configuration
  typedef struct packed {
    rateSelT rateSel;
    logic    crmDis;
    logic    edpDis;
    logic    ctlDis;
  } clkCfgT;

  // Registered EBOX clock enables
  typedef struct packed {
    logic ebox;
    logic crm;
    logic edp;
    logic ctl;
  } eboxClkEnT;

endpackage

// ==== logic/clkDiagApb.sv ====
module clkDiagApb (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  clkPkg::apbReqT    apbReq,
  output clkPkg::apbRspT    apbRsp,
  output clkPkg::clkFuncT   clkFunc,
  output logic              ldBurstLsb,
  output logic              ldBurstMsb,
  output logic              ldRate,
  output logic              ldDisable,
  output logic              clrReset,
  output logic              setReset,
  output clkPkg::diagDataT  ldData,
  input  clkPkg::clkCfgT    clkCfg,
  input  clkPkg::burstCountT burstCount,
  input  logic              go,
  input  logic              burstRun,
  input  logic              mrReset
);

  logic access;
  logic ctlWr;
  logic ldWr;
  logic rdSel;
  logic ctlOk;
  logic ldOk;
  logic [2:0] code;
  clkPkg::clkFuncT funcNext;
  clkPkg::diagDataT rdWord;

  // Zero wait states, access completes when psel and penable are both up
  assign access = apbReq.psel & apbReq.penable;
  assign code = apbReq.paddr[2:0];
  assign ctlWr = access & apbReq.pwrite & ~apbReq.paddr[3];
  assign ldWr = access & apbReq.pwrite & apbReq.paddr[3];
  // Reads ignore the group bit
  assign rdSel = apbReq.psel & ~apbReq.pwrite;

  // Control function decode
  always_comb begin
    funcNext = '0;
    ctlOk = 1'b0;
    case (clkPkg::ctlFuncE'(code))
      clkPkg::START: begin
        ctlOk = 1'b1;
        funcNext.start = 1'b1;
      end
      clkPkg::SINGLE_STEP: begin
        ctlOk = 1'b1;
        funcNext.step = 1'b1;
      end
      clkPkg::BURST: begin
        ctlOk = 1'b1;
        funcNext.burst = 1'b1;
      end
      // Reset functions act in clkFuncRegs
      clkPkg::CLR_RESET, clkPkg::SET_RESET: ctlOk = 1'b1;
      default: ctlOk = 1'b0;
    endcase
    // Every supported control write stops the clock first
    funcNext.anyCtl = ctlOk;
  end

  // Load function decode, only 042 to 045 remain
  always_comb begin
    case (code)
      clkPkg::LD_BURST_LSB,
      clkPkg::LD_BURST_MSB,
      clkPkg::LD_RATE,
      clkPkg::LD_DISABLE: ldOk = 1'b1;
      default: ldOk = 1'b0;
    endcase
  end

  // Load strobes act on the access edge itself
  assign ldBurstLsb = ldWr & (code == clkPkg::LD_BURST_LSB);
  assign ldBurstMsb = ldWr & (code == clkPkg::LD_BURST_MSB);
  assign ldRate = ldWr & (code == clkPkg::LD_RATE);
  assign ldDisable = ldWr & (code == clkPkg::LD_DISABLE);
  assign clrReset = ctlWr & (code == clkPkg::CLR_RESET);
  assign setReset = ctlWr & (code == clkPkg::SET_RESET);
  assign ldData = apbReq.pwdata;

  // Gate strobes, one cycle wide after the access edge
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      clkFunc <= '0;
    end else if (ctlWr) begin
      clkFunc <= funcNext;
    end else begin
      clkFunc <= '0;
    end
  end

  // Diagnostic readback mux
  always_comb begin
    case (code)
      clkPkg::RD_BURST: rdWord = burstCount[7:2];
      clkPkg::RD_STATUS: rdWord = {burstCount[1:0], go, burstRun, mrReset, 1'b0};
      clkPkg::RD_CONFIG: rdWord = {1'b0, clkCfg};
      default: rdWord = '0;
    endcase
  end

  assign apbRsp.pready = 1'b1;
  // Unsupported write codes are refused and change nothing
  assign apbRsp.pslverr = (ctlWr & ~ctlOk) | (ldWr & ~ldOk);
  assign apbRsp.prdata = rdSel ? rdWord : '0;

endmodule

// ==== logic/clkFuncRegs.sv ====
module clkFuncRegs (
  input  logic             MBOX_CLK,
  input  logic             CLK,
  input  logic             ldRate,
  input  logic             ldDisable,
  input  logic             clrReset,
  input  logic             setReset,
  input  clkPkg::diagDataT ldData,
  output clkPkg::clkCfgT   clkCfg,
  output logic             mrReset
);

  // Rate select from function 044
  // Source select is gone, so only the low two bits matter
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      clkCfg.rateSel <= '0;
    end else if (ldRate) begin
      clkCfg.rateSel <= ldData[1:0];
    end
  end

  // Section disables from function 045
  // Order is crm, edp, ctl with ctl in the LSB
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      clkCfg.crmDis <= 1'b0;
      clkCfg.edpDis <= 1'b0;
      clkCfg.ctlDis <= 1'b0;
    end else if (ldDisable) begin
      clkCfg.crmDis <= ldData[2];
      clkCfg.edpDis <= ldData[1];
      clkCfg.ctlDis <= ldData[0];
    end
  end

  // Master reset set/clear flip-flop
  // Comes up asserted, host releases it with CLR_RESET
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (clrReset) begin
      mrReset <= 1'b0;
    end else if (setReset) begin
      mrReset <= 1'b1;
    end
  end

endmodule

// ==== logic/burstCounter.sv ====
module burstCounter (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  logic               ldLsb,
  input  logic               ldMsb,
  input  logic               dec,
  input  clkPkg::diagDataT   ldData,
  output clkPkg::burstCountT count,
  output logic               zero
);

  // Counter stops at zero
  assign zero = (count == '0);

  // Two nibbles, loaded by 042 and 043
  // A load wins over a decrement in the same cycle
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      count <= '0;
    end else if (ldLsb) begin
      count[3:0] <= ldData[3:0];
    end else if (ldMsb) begin
      count[7:4] <= ldData[3:0];
    end else if (dec && !zero) begin
      // one EBOX tick consumed
      count <= count - 1'b1;
    end
  end

endmodule

// ==== logic/eboxClockGate.sv ====
module eboxClockGate (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  clkPkg::clkFuncT   clkFunc,
  input  clkPkg::clkCfgT    clkCfg,
  input  logic              burstZero,
  output logic              burstDec,
  output logic              go,
  output logic              burstRun,
  output clkPkg::eboxClkEnT clkEn
);

  logic [clkPkg::RATE_DIV_W-1:0] ratePhase;
  logic [clkPkg::RATE_DIV_W-1:0] rateMask;
  logic pendStep;
  logic opportunity;
  logic tick;

  // Free running rate phase, not touched by control writes
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      ratePhase <= '0;
    end else begin
      ratePhase <= ratePhase + 1'b1;
    end
  end

  // Low rateSel bits of the phase must be zero
  assign rateMask = ~({clkPkg::RATE_DIV_W{1'b1}} << clkCfg.rateSel);
  assign opportunity = ((ratePhase & rateMask) == '0);

  // Burst ticks stop once the count is used up
  assign burstDec = opportunity & burstRun & ~burstZero;
  assign tick = opportunity & (go | pendStep | (burstRun & ~burstZero));

  // Go, burst and single step latches
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      go <= 1'b0;
      burstRun <= 1'b0;
      pendStep <= 1'b0;
    end else if (clkFunc.anyCtl) begin
      // Old state dropped, new function applied
      go <= clkFunc.start;
      burstRun <= clkFunc.burst & ~burstZero;
      pendStep <= clkFunc.step;
    end else begin
      if (burstRun && burstZero) begin
        burstRun <= 1'b0;
      end
      // Step is used by its first opportunity
      if (tick) begin
        pendStep <= 1'b0;
      end
    end
  end

  // Registered enables, high one cycle after the tick decision
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      clkEn <= '0;
    end else begin
      clkEn.ebox <= tick;
      clkEn.crm <= tick & ~clkCfg.crmDis;
      clkEn.edp <= tick & ~clkCfg.edpDis;
      clkEn.ctl <= tick & ~clkCfg.ctlDis;
    end
  end

endmodule

// ==== logic/clkBoard.sv ====
module clkBoard (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  clkPkg::apbReqT    apbReq,
  output clkPkg::apbRspT    apbRsp,
  output clkPkg::eboxClkEnT clkEn,
  output logic              mrReset
);

  // Decoder to registers and counter
  clkPkg::clkFuncT funcStb;
  logic ldBurstLsb;
  logic ldBurstMsb;
  logic ldRate;
  logic ldDisable;
  logic clrReset;
  logic setReset;
  clkPkg::diagDataT ldData;

  // Status back to the readback mux
  clkPkg::clkCfgT clkCfg;
  clkPkg::burstCountT burstCount;
  logic burstZero;
  logic burstDec;
  logic go;
  logic burstRun;

  // Function decode and readback
  clkDiagApb clkDiagApb_inst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .clkFunc    (funcStb),
    .ldBurstLsb (ldBurstLsb),
    .ldBurstMsb (ldBurstMsb),
    .ldRate     (ldRate),
    .ldDisable  (ldDisable),
    .clrReset   (clrReset),
    .setReset   (setReset),
    .ldData     (ldData),
    .clkCfg     (clkCfg),
    .burstCount (burstCount),
    .go         (go),
    .burstRun   (burstRun),
    .mrReset    (mrReset)
  );

  clkFuncRegs clkFuncRegs_inst (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .ldRate    (ldRate),
    .ldDisable (ldDisable),
    .clrReset  (clrReset),
    .setReset  (setReset),
    .ldData    (ldData),
    .clkCfg    (clkCfg),
    .mrReset   (mrReset)
  );

  burstCounter burstCounter_inst (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .ldLsb    (ldBurstLsb),
    .ldMsb    (ldBurstMsb),
    .dec      (burstDec),
    .ldData   (ldData),
    .count    (burstCount),
    .zero     (burstZero)
  );

  // EBOX clock gate
  eboxClockGate eboxClockGate_inst (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .clkFunc   (funcStb),
    .clkCfg    (clkCfg),
    .burstZero (burstZero),
    .burstDec  (burstDec),
    .go        (go),
    .burstRun  (burstRun),
    .clkEn     (clkEn)
  );

endmodule

// ==== bench/clkBoard_props.sv ====
module clkBoard_props (
  input logic              MBOX_CLK,
  input logic              CLK,
  input clkPkg::apbReqT    apbReq,
  input clkPkg::apbRspT    apbRsp,
  input clkPkg::eboxClkEnT clkEn
);
  timeunit 1ns;
  timeprecision 100ps;

  logic refused;

  // Refused codes are control 0, 3, 4 and load 040, 041, 046, 047
  assign refused = apbReq.psel && apbReq.penable && apbReq.pwrite &&
                   (apbReq.paddr inside {4'h0, 4'h3, 4'h4, 4'h8, 4'h9, 4'hE, 4'hF});

  // Error response only with ready, and exactly on a refused write access
  errWithReady: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    apbRsp.pready && (apbRsp.pslverr == refused))
    else $error("pslverr does not match a refused write access");

  // Section clocks never run without the EBOX clock
  sectionWithEbox: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (clkEn.crm || clkEn.edp || clkEn.ctl) |-> clkEn.ebox)
    else $error("section enable without ebox enable");

  // Gate quiet while reset is held
  quietInReset: assert property (@(posedge MBOX_CLK)
    CLK |-> (clkEn == '0))
    else $error("clock enable active during reset");

endmodule

bind clkBoard clkBoard_props clkBoard_props_inst (
  .MBOX_CLK (MBOX_CLK),
  .CLK      (CLK),
  .apbReq   (apbReq),
  .apbRsp   (apbRsp),
  .clkEn    (clkEn)
);

// ==== bench/clkBoardTb.sv ====
module clkBoardTb;
  timeunit 1ns;
  timeprecision 100ps;

  logic MBOX_CLK;
  logic CLK;
  clkPkg::apbReqT apbReq;
  clkPkg::apbRspT apbRsp;
  clkPkg::eboxClkEnT clkEn;
  logic mrReset;

  // Shadow of the written registers
  clkPkg::burstCountT shCount;
  clkPkg::clkCfgT shCfg;
  logic shGo;
  logic shMr;

  // Pulse counters in the order ebox, crm, edp, ctl
  int pulses [4] = '{0, 0, 0, 0};
  int snap [4];
  int cycleNo = 0;
  int lastEbox = 0;
  int accCycle = 0;
  int errCount = 0;
  int rndSeed;
  int base;
  int n;
  int expCnt;
  logic err;
  clkPkg::diagDataT d;
  clkPkg::diagAddrT badCode [7] = '{4'h0, 4'h3, 4'h4, 4'h8, 4'h9, 4'hE, 4'hF};
  logic [2:0] rdCodes [4] = '{3'd0, 3'd1, 3'd2, 3'd5};

  clkBoard clkBoard_inst (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .clkEn    (clkEn),
    .mrReset  (mrReset)
  );

  // 8 ns MBOX clock
  always #4 MBOX_CLK = ~MBOX_CLK;

  // Comparing process, counts enable cycles away from the active edge
  always @(negedge MBOX_CLK) begin
    cycleNo <= cycleNo + 1;
    if (!CLK) begin
      if (clkEn.ebox) begin
        pulses[0] <= pulses[0] + 1;
        lastEbox <= cycleNo;
      end
      pulses[1] <= pulses[1] + int'(clkEn.crm);
      pulses[2] <= pulses[2] + int'(clkEn.edp);
      pulses[3] <= pulses[3] + int'(clkEn.ctl);
    end
  end

  // Expected readback word from the shadow registers
  // Readback is only compared while no burst runs
  function automatic clkPkg::diagDataT refRead(input logic [2:0] code);
    case (code)
      clkPkg::RD_BURST: return shCount[7:2];
      clkPkg::RD_STATUS: return {shCount[1:0], shGo, 1'b0, shMr, 1'b0};
      clkPkg::RD_CONFIG: return {1'b0, shCfg};
      default: return '0;
    endcase
  endfunction

  // One opportunity every 2^rate cycles
  function automatic int refStartPulses(input clkPkg::rateSelT rate, input int window);
    return window >> rate;
  endfunction

  task automatic failRun(input string msg);
    errCount++;
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkData(input string name, input clkPkg::diagDataT got,
                           input clkPkg::diagDataT exp);
    if (got !== exp) begin
      failRun($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkEn(input string name, input clkPkg::eboxClkEnT got,
                         input clkPkg::eboxClkEnT exp);
    if (got !== exp) begin
      failRun($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic checkCount(input string name, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
      failRun($sformatf("ERR %0t %s got %0d expected %0d to %0d", $time, name, got, lo, hi));
    end
  endtask

  // Setup then access phase, slave response sampled mid access
  task automatic apbWrite(input clkPkg::diagAddrT addr, input clkPkg::diagDataT data,
                          output logic slvErr);
    @(posedge MBOX_CLK);
    apbReq <= {1'b1, 1'b0, 1'b1, addr, data};
    @(posedge MBOX_CLK);
    apbReq.penable <= 1'b1;
    @(negedge MBOX_CLK);
    slvErr = apbRsp.pslverr;
    accCycle = cycleNo;
    // Zero wait states
    checkBit("pready", apbRsp.pready, 1'b1);
    // Access edge
    @(posedge MBOX_CLK);
    apbReq <= '0;
  endtask

  task automatic apbRead(input clkPkg::diagAddrT addr, output clkPkg::diagDataT data);
    @(posedge MBOX_CLK);
    apbReq <= {1'b1, 1'b0, 1'b0, addr, 6'd0};
    @(posedge MBOX_CLK);
    apbReq.penable <= 1'b1;
    @(negedge MBOX_CLK);
    data = apbRsp.prdata;
    checkBit("pready", apbRsp.pready, 1'b1);
    @(posedge MBOX_CLK);
    apbReq <= '0;
  endtask

  task automatic writeOk(input clkPkg::diagAddrT addr, input clkPkg::diagDataT data);
    logic slvErr;
    apbWrite(addr, data, slvErr);
    checkBit("pslverr", slvErr, 1'b0);
  endtask

  task automatic readAll();
    clkPkg::diagDataT got;
    foreach (rdCodes[i]) begin
      apbRead({1'b0, rdCodes[i]}, got);
      checkData($sformatf("prdata code %0d", rdCodes[i]), got, refRead(rdCodes[i]));
    end
    checkBit("mrReset", mrReset, shMr);
  endtask

  task automatic setRate(input clkPkg::rateSelT rate);
    writeOk({1'b1, clkPkg::LD_RATE}, {4'd0, rate});
    shCfg.rateSel = rate;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge MBOX_CLK);
  endtask

  task automatic waitPulses(input int target, input int limit);
    int cyc;
    cyc = 0;
    while (pulses[0] < target) begin
      if (cyc == limit) begin
        failRun("timeout while waiting for an ebox pulse");
      end
      @(negedge MBOX_CLK);
      cyc++;
    end
  endtask

  // Poll status until burstRun drops
  task automatic waitBurstDone(input int limit);
    int cyc;
    clkPkg::diagDataT st;
    cyc = 0;
    st = 6'b000100;
    while (st[2]) begin
      if (cyc == limit) begin
        failRun("timeout while waiting for the burst to finish");
      end
      apbRead({1'b0, clkPkg::RD_STATUS}, st);
      cyc++;
    end
  endtask

  initial begin
    MBOX_CLK = 1'b0;
    CLK = 1'b0;
    apbReq = '0;
    shCount = '0;
    shCfg = '0;
    shGo = 1'b0;
    shMr = 1'b1;
    rndSeed = $urandom(32'h7df2_03ea);
    #1 CLK = 1'b1;
    repeat (5) @(posedge MBOX_CLK);
    CLK <= 1'b0;

    // Reset state and a quiet clock
    idle(10);
    readAll();
    @(negedge MBOX_CLK);
    checkEn("clkEn", clkEn, '0);
    checkCount("ebox pulses after reset", pulses[0], 0, 0);

    // Load functions read back exactly
    repeat (4) begin
      d = clkPkg::diagDataT'($urandom);
      writeOk({1'b1, clkPkg::LD_BURST_LSB}, d);
      shCount[3:0] = d[3:0];
      d = clkPkg::diagDataT'($urandom);
      writeOk({1'b1, clkPkg::LD_BURST_MSB}, d);
      shCount[7:4] = d[3:0];
      d = clkPkg::diagDataT'($urandom);
      setRate(d[1:0]);
      d = clkPkg::diagDataT'($urandom);
      writeOk({1'b1, clkPkg::LD_DISABLE}, d);
      // crm, edp, ctl from bit 2 down
      shCfg[2:0] = d[2:0];
      readAll();
    end

    // Unsupported codes are refused
    foreach (badCode[i]) begin
      apbWrite(badCode[i], clkPkg::diagDataT'($urandom), err);
      checkBit("pslverr", err, 1'b1);
      readAll();
    end

    // Single step at every rate
    for (int r = 0; r < 4; r++) begin
      setRate(r);
      base = pulses[0];
      writeOk({1'b0, clkPkg::SINGLE_STEP}, '0);
      waitPulses(base + 1, 20);
      if (r == 0) begin
        // Sample point sits half a cycle before the access edge
        checkCount("step latency", lastEbox - accCycle, 3, 3);
      end
      idle(16);
      checkCount("step pulses", pulses[0] - base, 1, 1);
    end

    // Bursts of random length and rate
    repeat (5) begin
      n = $urandom_range(40, 0);
      setRate($urandom_range(3, 0));
      writeOk({1'b1, clkPkg::LD_BURST_LSB}, n[3:0]);
      writeOk({1'b1, clkPkg::LD_BURST_MSB}, n[7:4]);
      base = pulses[0];
      writeOk({1'b0, clkPkg::BURST}, '0);
      waitBurstDone(200);
      idle(4);
      checkCount("burst pulses", pulses[0] - base, n, n);
      shCount = '0;
      readAll();
    end

    // Free run, stop with SET_RESET, release with CLR_RESET
    for (int r = 0; r < 4; r++) begin
      setRate(r);
      writeOk({1'b0, clkPkg::START}, '0);
      shGo = 1'b1;
      readAll();
      base = pulses[0];
      idle(64);
      expCnt = refStartPulses(r, 64);
      checkCount("start pulses", pulses[0] - base, expCnt - 1, expCnt + 1);
      writeOk({1'b0, clkPkg::SET_RESET}, '0);
      shGo = 1'b0;
      shMr = 1'b1;
      // Last tick may still be in flight
      idle(3);
      base = pulses[0];
      idle(32);
      checkCount("pulses after stop", pulses[0] - base, 0, 0);
      readAll();
      writeOk({1'b0, clkPkg::CLR_RESET}, '0);
      shMr = 1'b0;
      readAll();
    end

    // Section disables at full rate
    setRate(0);
    for (int dis = 1; dis < 8; dis++) begin
      writeOk({1'b1, clkPkg::LD_DISABLE}, dis);
      shCfg[2:0] = dis;
      writeOk({1'b0, clkPkg::START}, '0);
      idle(4);
      snap = pulses;
      idle(16);
      checkCount("ebox pulses", pulses[0] - snap[0], 16, 16);
      for (int s = 1; s < 4; s++) begin
        expCnt = dis[3 - s] ? 0 : 16;
        checkCount($sformatf("section %0d pulses", s), pulses[s] - snap[s], expCnt, expCnt);
      end
      @(negedge MBOX_CLK);
      checkEn("clkEn", clkEn, {1'b1, ~shCfg.crmDis, ~shCfg.edpDis, ~shCfg.ctlDis});
      writeOk({1'b0, clkPkg::CLR_RESET}, '0);
    end
    idle(4);
    readAll();

    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/clkPkg.sv
logic/clkDiagApb.sv
logic/clkFuncRegs.sv
logic/burstCounter.sv
logic/eboxClockGate.sv
logic/clkBoard.sv
bench/clkBoard_props.sv
bench/clkBoardTb.sv
